// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_issue.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_writeback.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

// File: flist.f
rv_pkg.sv
rv_issue.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_rv_core.sv

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
(
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_instr_valid,
    input  wire rv_pkg::instr_u     i_instr,
    output logic                    o_instr_credit,
    output rv_pkg::wb_s             o_wb,
    input  wire                     i_wb_credit
);

    logic                           iss_pop;
    rv_pkg::instr_u                 iss_word;
    rv_pkg::dec_s                   dec;
    logic [rv_pkg::XLEN-1:0]        rf_rdata1;
    logic [rv_pkg::XLEN-1:0]        rf_rdata2;
    rv_pkg::exe_s                   exe;
    rv_pkg::exe_s                   wb_fwd;
    logic                           wb_we;
    logic [rv_pkg::REG_ADDR_W-1:0]  wb_rd;
    logic [rv_pkg::XLEN-1:0]        wb_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue, decode, execute, writeback.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rv_issue u_issue
    (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_instr_valid      (i_instr_valid),
        .i_instr            (i_instr),
        .i_wb_credit        (i_wb_credit),
        .o_instr_credit     (o_instr_credit),
        .o_pop              (iss_pop),
        .o_word             (iss_word)
    );

    rv_decode u_decode
    (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_pop              (iss_pop),
        .i_word             (iss_word),
        .o_dec              (dec)
    );

    rv_regfile u_regfile
    (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_rs1              (dec.rs1),
        .i_rs2              (dec.rs2),
        .i_we               (wb_we),
        .i_rd               (wb_rd),
        .i_wdata            (wb_wdata),
        .o_rdata1           (rf_rdata1),
        .o_rdata2           (rf_rdata2)
    );

    rv_execute u_execute
    (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_dec              (dec),
        .i_rdata1           (rf_rdata1),
        .i_rdata2           (rf_rdata2),
        .i_wb_fwd           (wb_fwd),
        .o_exe              (exe)
    );

    rv_writeback u_writeback
    (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_exe              (exe),
        .o_we               (wb_we),
        .o_rd               (wb_rd),
        .o_wdata            (wb_wdata),
        .o_fwd              (wb_fwd),
        .o_wb               (o_wb)
    );

endmodule

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_pop,
    input  wire rv_pkg::instr_u     i_word,
    output rv_pkg::dec_s            o_dec
);

    rv_pkg::dec_s   dec_next;
    logic [6:0]     upper;

    // Funct7 for OP, imm12[11:5] for OP-IMM shifts. Same bits.
    assign upper = i_word.r_fields.funct7;

    always_comb
    begin
        dec_next         = '0;
        dec_next.valid   = i_pop;
        dec_next.rs1     = i_word.r_fields.rs1;
        dec_next.rd      = i_word.r_fields.rd;
        dec_next.alu_op  = rv_pkg::ALU_ADD;
        case (i_word.r_fields.opcode)
            rv_pkg::OPC_OP:
            begin
                dec_next.rs2 = i_word.r_fields.rs2;
                case (i_word.r_fields.funct3)
                    rv_pkg::FUNCT3_ADD_SUB: dec_next.alu_op = (upper == rv_pkg::FUNCT7_ALT) ?
                                                rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    rv_pkg::FUNCT3_SLL:     dec_next.alu_op = rv_pkg::ALU_SLL;
                    rv_pkg::FUNCT3_SLT:     dec_next.alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::FUNCT3_SLTU:    dec_next.alu_op = rv_pkg::ALU_SLTU;
                    rv_pkg::FUNCT3_XOR:     dec_next.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::FUNCT3_SRL_SRA: dec_next.alu_op = (upper == rv_pkg::FUNCT7_ALT) ?
                                                rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::FUNCT3_OR:      dec_next.alu_op = rv_pkg::ALU_OR;
                    default:                dec_next.alu_op = rv_pkg::ALU_AND;
                endcase
                // Only ADD/SUB and SRL/SRA accept the alternate funct7.
                if (upper != 7'b0000000)
                    dec_next.illegal = !((upper == rv_pkg::FUNCT7_ALT) &&
                        ((i_word.r_fields.funct3 == rv_pkg::FUNCT3_ADD_SUB) ||
                         (i_word.r_fields.funct3 == rv_pkg::FUNCT3_SRL_SRA)));
            end
            rv_pkg::OPC_OP_IMM:
            begin
                dec_next.use_imm = 1'b1;
                dec_next.imm     = {{(rv_pkg::XLEN-12){i_word.i_fields.imm12[11]}},
                                    i_word.i_fields.imm12};
                case (i_word.i_fields.funct3)
                    rv_pkg::FUNCT3_ADD_SUB: dec_next.alu_op = rv_pkg::ALU_ADD;
                    rv_pkg::FUNCT3_SLT:     dec_next.alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::FUNCT3_SLTU:    dec_next.alu_op = rv_pkg::ALU_SLTU;
                    rv_pkg::FUNCT3_XOR:     dec_next.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::FUNCT3_OR:      dec_next.alu_op = rv_pkg::ALU_OR;
                    rv_pkg::FUNCT3_AND:     dec_next.alu_op = rv_pkg::ALU_AND;
                    default:
                    begin
                        // Immediate shifts.
                        dec_next.imm     = {{(rv_pkg::XLEN-5){1'b0}}, i_word.i_fields.imm12[4:0]};
                        dec_next.alu_op  = (i_word.i_fields.funct3 == rv_pkg::FUNCT3_SLL) ?
                                           rv_pkg::ALU_SLL :
                                           (upper == rv_pkg::FUNCT7_ALT) ? rv_pkg::ALU_SRA :
                                           rv_pkg::ALU_SRL;
                        dec_next.illegal = (upper != 7'b0000000) &&
                            !((upper == rv_pkg::FUNCT7_ALT) &&
                              (i_word.i_fields.funct3 == rv_pkg::FUNCT3_SRL_SRA));
                    end
                endcase
            end
            default: dec_next.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        o_dec <= dec_next;
        if (i_rst)
            o_dec.valid <= 1'b0;
    end

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire rv_pkg::dec_s           i_dec,
    input  wire [rv_pkg::XLEN-1:0]      i_rdata1,
    input  wire [rv_pkg::XLEN-1:0]      i_rdata2,
    input  wire rv_pkg::exe_s           i_wb_fwd,
    output rv_pkg::exe_s                o_exe
);

    logic [rv_pkg::XLEN-1:0]    op1;
    logic [rv_pkg::XLEN-1:0]    op2;
    logic [4:0]                 shamt;
    logic [rv_pkg::XLEN-1:0]    alu_res;
    rv_pkg::exe_s               exe_next;

    function automatic logic fwd_hit(input rv_pkg::exe_s rec,
                                     input logic [rv_pkg::REG_ADDR_W-1:0] rs);
        return rec.valid && !rec.illegal && (rec.rd != '0) && (rec.rd == rs);
    endfunction

    // Execute register first, then writeback, then the register file.
    function automatic logic [rv_pkg::XLEN-1:0] pick_operand(
        input logic [rv_pkg::REG_ADDR_W-1:0] rs,
        input logic [rv_pkg::XLEN-1:0]       rf_data,
        input rv_pkg::exe_s                  ex_rec,
        input rv_pkg::exe_s                  wb_rec);
        if (fwd_hit(ex_rec, rs))
            return ex_rec.result;
        else if (fwd_hit(wb_rec, rs))
            return wb_rec.result;
        else
            return rf_data;
    endfunction

    always_comb
    begin
        op1   = pick_operand(i_dec.rs1, i_rdata1, o_exe, i_wb_fwd);
        op2   = i_dec.use_imm ? i_dec.imm : pick_operand(i_dec.rs2, i_rdata2, o_exe, i_wb_fwd);
        shamt = op2[4:0];
        case (i_dec.alu_op)
            rv_pkg::ALU_ADD:  alu_res = op1 + op2;
            rv_pkg::ALU_SUB:  alu_res = op1 - op2;
            rv_pkg::ALU_AND:  alu_res = op1 & op2;
            rv_pkg::ALU_OR:   alu_res = op1 | op2;
            rv_pkg::ALU_XOR:  alu_res = op1 ^ op2;
            rv_pkg::ALU_SLT:  alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, op1 < op2};
            rv_pkg::ALU_SLL:  alu_res = op1 << shamt;
            rv_pkg::ALU_SRL:  alu_res = op1 >> shamt;
            rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(op1) >>> shamt);
            default:          alu_res = '0;
        endcase

        exe_next.valid   = i_dec.valid;
        exe_next.rd      = i_dec.rd;
        exe_next.illegal = i_dec.illegal;
        // Nothing is reported for x0 or an illegal word.
        exe_next.result  = (i_dec.illegal || (i_dec.rd == '0)) ? '0 : alu_res;
    end

    always_ff @(posedge i_clk)
    begin
        o_exe <= exe_next;
        if (i_rst)
            o_exe.valid <= 1'b0;
    end

endmodule

`default_nettype wire

// File: rv_issue.sv
`timescale 1ns/1ps
`default_nettype none

module rv_issue
(
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_instr_valid,
    input  wire rv_pkg::instr_u     i_instr,
    input  wire                     i_wb_credit,
    output logic                    o_instr_credit,
    output logic                    o_pop,
    output rv_pkg::instr_u          o_word
);

    rv_pkg::instr_u                 iq_mem [rv_pkg::IQ_DEPTH];
    logic [rv_pkg::IQ_PTR_W-1:0]    wr_ptr;
    logic [rv_pkg::IQ_PTR_W-1:0]    rd_ptr;
    logic [rv_pkg::CREDIT_W-1:0]    iq_count;
    logic [rv_pkg::CREDIT_W-1:0]    wb_credits;

    // Result credits are reserved at issue, so nothing waits downstream.
    assign o_pop          = (iq_count != '0) && (wb_credits != '0);
    assign o_word         = iq_mem[rd_ptr];
    assign o_instr_credit = o_pop;

    always_ff @(posedge i_clk)
    begin
        if (i_instr_valid)
        begin
            iq_mem[wr_ptr] <= i_instr;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            iq_count   <= '0;
            wb_credits <= rv_pkg::CREDIT_W'(rv_pkg::WB_CREDITS);
        end
        else
        begin
            if (i_instr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (o_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({i_instr_valid, o_pop})
                2'b10:   iq_count <= iq_count + 1'b1;
                2'b01:   iq_count <= iq_count - 1'b1;
                default: iq_count <= iq_count;
            endcase
            case ({i_wb_credit, o_pop})
                2'b10:   wb_credits <= wb_credits + 1'b1;
                2'b01:   wb_credits <= wb_credits - 1'b1;
                default: wb_credits <= wb_credits;
            endcase
        end
    end

    // Source sends only while it holds an input credit.
    a_no_push_on_full: assert property (@(posedge i_clk) disable iff (i_rst)
        i_instr_valid |-> (iq_count < rv_pkg::IQ_DEPTH));

    // Sink never returns more credits than records it was sent.
    a_credit_bound: assert property (@(posedge i_clk) disable iff (i_rst)
        wb_credits <= rv_pkg::WB_CREDITS);

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes and credit depths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IQ_DEPTH   = 4;
    localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);
    localparam int WB_CREDITS = 4;
    // Holds 0 to 4.
    localparam int CREDIT_W   = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ISA field encodings.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OPC_OP          = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM      = 7'b0010011;

    localparam logic [2:0] FUNCT3_ADD_SUB  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL      = 3'b001;
    localparam logic [2:0] FUNCT3_SLT      = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU     = 3'b011;
    localparam logic [2:0] FUNCT3_XOR      = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA  = 3'b101;
    localparam logic [2:0] FUNCT3_OR       = 3'b110;
    localparam logic [2:0] FUNCT3_AND      = 3'b111;

    // SUB and SRA.
    localparam logic [6:0] FUNCT7_ALT      = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    // One instruction word, seen as R-type or as I-type.
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_fields;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fields;
    } instr_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
    } dec_s;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  illegal;
    } exe_s;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  illegal;
    } wb_s;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire [rv_pkg::REG_ADDR_W-1:0]    i_rs1,
    input  wire [rv_pkg::REG_ADDR_W-1:0]    i_rs2,
    input  wire                             i_we,
    input  wire [rv_pkg::REG_ADDR_W-1:0]    i_rd,
    input  wire [rv_pkg::XLEN-1:0]          i_wdata,
    output logic [rv_pkg::XLEN-1:0]         o_rdata1,
    output logic [rv_pkg::XLEN-1:0]         o_rdata2
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

    // X0 reads zero, a same-cycle write is passed through.
    function automatic logic [rv_pkg::XLEN-1:0] read_port(input logic [rv_pkg::REG_ADDR_W-1:0] rs);
        if (rs == '0)
            return '0;
        else if (i_we && (i_rd == rs))
            return i_wdata;
        else
            return regs[rs];
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            regs <= '{default: '0};
        else if (i_we && (i_rd != '0))
            regs[i_rd] <= i_wdata;
    end

    always_comb
    begin
        o_rdata1 = read_port(i_rs1);
        o_rdata2 = read_port(i_rs2);
    end

endmodule

`default_nettype wire

// File: rv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module rv_writeback
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire rv_pkg::exe_s               i_exe,
    output logic                            o_we,
    output logic [rv_pkg::REG_ADDR_W-1:0]   o_rd,
    output logic [rv_pkg::XLEN-1:0]         o_wdata,
    output rv_pkg::exe_s                    o_fwd,
    output rv_pkg::wb_s                     o_wb
);

    rv_pkg::exe_s wb_q;

    // Commit at the same edge that loads the result record.
    assign o_we    = i_exe.valid && !i_exe.illegal && (i_exe.rd != '0);
    assign o_rd    = i_exe.rd;
    assign o_wdata = i_exe.result;

    always_ff @(posedge i_clk)
    begin
        wb_q <= i_exe;
        if (i_rst)
            wb_q.valid <= 1'b0;
    end

    assign o_fwd = wb_q;

    always_comb
    begin
        o_wb.valid   = wb_q.valid;
        o_wb.rd      = wb_q.rd;
        o_wb.value   = wb_q.result;
        o_wb.illegal = wb_q.illegal;
    end

    // Execute reports zero for x0 and illegal records.
    a_silent_record: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_exe.valid && (i_exe.illegal || (i_exe.rd == '0))) |-> (i_exe.result == '0));

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int WAIT_LIMIT = 200;

    logic           clk;
    logic           rst;
    logic           instr_valid;
    rv_pkg::instr_u instr;
    logic           instr_credit;
    rv_pkg::wb_s    wb;
    logic           wb_credit = 1'b0;

    logic [rv_pkg::XLEN-1:0] model_regs [rv_pkg::NUM_REGS];
    rv_pkg::wb_s    exp_q [$];
    rv_pkg::wb_s    expected;
    int             due_q [$];
    int             cycle;
    int             sink_max_delay;
    int             words_sent;
    int             credit_pulses;
    int             seq_errors;
    int             cmp_errors;
    int             sink_errors;
    int             mon_errors;
    int             timeouts;
    int             checks_done;
    int             errors_at_start;
    int             tests_passed;
    int             tests_failed;

    rv_core rv_core_i
    (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .o_instr_credit (instr_credit),
        .o_wb           (wb),
        .i_wb_credit    (wb_credit)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction builders and the ISA reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic rv_pkg::instr_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        rv_pkg::instr_u w;
        w.r_fields = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
        return w;
    endfunction

    function automatic rv_pkg::instr_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        rv_pkg::instr_u w;
        w.i_fields = {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
        return w;
    endfunction

    // Ten register forms, then nine immediate forms.
    function automatic rv_pkg::instr_u op_word(input int k, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        case (k)
            0:       return r_word(7'h00, rs2, rs1, 3'd0, rd);
            1:       return r_word(7'h20, rs2, rs1, 3'd0, rd);
            2:       return r_word(7'h00, rs2, rs1, 3'd7, rd);
            3:       return r_word(7'h00, rs2, rs1, 3'd6, rd);
            4:       return r_word(7'h00, rs2, rs1, 3'd4, rd);
            5:       return r_word(7'h00, rs2, rs1, 3'd2, rd);
            6:       return r_word(7'h00, rs2, rs1, 3'd3, rd);
            7:       return r_word(7'h00, rs2, rs1, 3'd1, rd);
            8:       return r_word(7'h00, rs2, rs1, 3'd5, rd);
            9:       return r_word(7'h20, rs2, rs1, 3'd5, rd);
            10:      return i_word(imm, rs1, 3'd0, rd);
            11:      return i_word(imm, rs1, 3'd7, rd);
            12:      return i_word(imm, rs1, 3'd6, rd);
            13:      return i_word(imm, rs1, 3'd4, rd);
            14:      return i_word(imm, rs1, 3'd2, rd);
            15:      return i_word(imm, rs1, 3'd3, rd);
            16:      return i_word({7'h00, imm[4:0]}, rs1, 3'd1, rd);
            17:      return i_word({7'h00, imm[4:0]}, rs1, 3'd5, rd);
            default: return i_word({7'h20, imm[4:0]}, rs1, 3'd5, rd);
        endcase
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + $urandom_range(28));
    endfunction

    function automatic rv_pkg::instr_u rand_word();
        if ($urandom_range(15) == 0)
            return rv_pkg::instr_u'($urandom());
        return op_word($urandom_range(18), rand_reg(), 5'($urandom()), 5'($urandom()),
                       12'($urandom()));
    endfunction

    // Executes one word on the model registers.
    function automatic rv_pkg::wb_s expected_result(input rv_pkg::instr_u w);
        rv_pkg::wb_s      r;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      res;
        logic [6:0]       f7;
        logic [2:0]       f3;
        logic             is_op;
        logic             is_shift;
        logic             legal;
        f7       = w.r_fields.funct7;
        f3       = w.r_fields.funct3;
        is_op    = (w.r_fields.opcode == rv_pkg::OPC_OP);
        is_shift = (f3 == rv_pkg::FUNCT3_SLL) || (f3 == rv_pkg::FUNCT3_SRL_SRA);
        a        = model_regs[w.r_fields.rs1];
        if (is_op)
            b = model_regs[w.r_fields.rs2];
        else
            b = {{20{w.i_fields.imm12[11]}}, w.i_fields.imm12};
        if (is_op)
            legal = (f7 == 7'h00) || ((f7 == rv_pkg::FUNCT7_ALT) &&
                    ((f3 == rv_pkg::FUNCT3_ADD_SUB) || (f3 == rv_pkg::FUNCT3_SRL_SRA)));
        else if (w.i_fields.opcode == rv_pkg::OPC_OP_IMM)
            legal = !is_shift || (f7 == 7'h00) ||
                    ((f7 == rv_pkg::FUNCT7_ALT) && (f3 == rv_pkg::FUNCT3_SRL_SRA));
        else
            legal = 1'b0;
        case (f3)
            rv_pkg::FUNCT3_ADD_SUB: res = (is_op && (f7 == rv_pkg::FUNCT7_ALT)) ? a - b : a + b;
            rv_pkg::FUNCT3_SLL:     res = a << b[4:0];
            rv_pkg::FUNCT3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_pkg::FUNCT3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            rv_pkg::FUNCT3_XOR:     res = a ^ b;
            rv_pkg::FUNCT3_SRL_SRA:
            begin
                if (f7 == rv_pkg::FUNCT7_ALT)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            rv_pkg::FUNCT3_OR:      res = a | b;
            default:                res = a & b;
        endcase
        r.valid   = 1'b1;
        r.rd      = w.r_fields.rd;
        r.illegal = !legal;
        r.value   = (legal && (r.rd != 5'd0)) ? res : 32'd0;
        if (legal && (r.rd != 5'd0))
            model_regs[r.rd] = res;
        return r;
    endfunction

    function automatic int src_credits();
        return rv_pkg::IQ_DEPTH + credit_pulses - words_sent;
    endfunction

    function automatic int total_errors();
        return seq_errors + cmp_errors + sink_errors + mon_errors + timeouts;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source, sink and result checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic note_timeout(input string why);
        $display("ERROR: %s", why);
        timeouts++;
    endtask

    task automatic send_word(input rv_pkg::instr_u w);
        int waited;
        waited = 0;
        if (timeouts == 0)
        begin
            @(posedge clk);
            while ((src_credits() <= 0) && (waited < WAIT_LIMIT))
            begin
                instr_valid <= 1'b0;
                @(posedge clk);
                waited++;
            end
            if (waited >= WAIT_LIMIT)
                note_timeout("no input credit came back from the core");
            else
            begin
                instr_valid <= 1'b1;
                instr       <= w;
                words_sent++;
                exp_q.push_back(expected_result(w));
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        if (timeouts == 0)
        begin
            @(posedge clk);
            instr_valid <= 1'b0;
            while (((exp_q.size() != 0) || (due_q.size() != 0)) && (waited < WAIT_LIMIT))
            begin
                @(posedge clk);
                waited++;
            end
            if (waited >= WAIT_LIMIT)
                note_timeout("records stopped arriving before all instructions retired");
        end
    endtask

    task automatic finish_test(input string name);
        if (total_errors() == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, total_errors() - errors_at_start);
        end
        errors_at_start = total_errors();
    endtask

    // Each record gives its credit back after a random delay.
    always @(posedge clk)
    begin
        cycle++;
        if (rst)
        begin
            wb_credit <= 1'b0;
            due_q.delete();
        end
        else
        begin
            if (wb.valid)
                due_q.push_back(cycle + $urandom_range(sink_max_delay));
            if (due_q.size() > rv_pkg::WB_CREDITS)
            begin
                $display("ERROR: sink holds %0d records, more than the core's credits",
                         due_q.size());
                sink_errors++;
            end
            if ((due_q.size() != 0) && (due_q[0] <= cycle))
            begin
                wb_credit <= 1'b1;
                void'(due_q.pop_front());
            end
            else
                wb_credit <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (instr_credit)
                credit_pulses++;
            if ((words_sent == 0) && (instr_credit || wb.valid))
            begin
                $display("ERROR: core output active before the first word was sent");
                mon_errors++;
            end
            if ((src_credits() < 0) || (src_credits() > rv_pkg::IQ_DEPTH))
            begin
                $display("ERROR: source credit count left the range 0 to %0d",
                         rv_pkg::IQ_DEPTH);
                mon_errors++;
            end
        end
    end

    always @(posedge clk)
    begin
        if (!rst && wb.valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("ERROR: result record for x%0d with no instruction outstanding", wb.rd);
                cmp_errors++;
            end
            else
            begin
                expected = exp_q.pop_front();
                checks_done++;
                if (wb.rd !== expected.rd)
                begin
                    $display("mismatch o_wb.rd: got 0x%02h expected 0x%02h", wb.rd, expected.rd);
                    cmp_errors++;
                end
                if (wb.value !== expected.value)
                begin
                    $display("mismatch o_wb.value: got 0x%08h expected 0x%08h",
                             wb.value, expected.value);
                    cmp_errors++;
                end
                if (wb.illegal !== expected.illegal)
                begin
                    $display("mismatch o_wb.illegal: got 0x%01h expected 0x%01h",
                             wb.illegal, expected.illegal);
                    cmp_errors++;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        int         k;
        int         n;
        logic [4:0] rs2;
        logic [11:0] imm;
        void'($urandom(80845));
        clk            = 1'b0;
        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr          = '0;
        sink_max_delay = 6;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        // Random 32-bit values in x1 to x29, shift amount 31 in x30.
        for (n = 1; n < 30; n++)
        begin
            send_word(i_word(12'($urandom()), 5'd0, 3'd0, 5'(n)));
            send_word(i_word(12'd20, 5'(n), 3'd1, 5'(n)));
            send_word(i_word(12'($urandom()), 5'(n), 3'd4, 5'(n)));
        end
        send_word(i_word(12'd31, 5'd0, 3'd0, 5'd30));
        for (k = 0; k < 19; k++)
        begin
            for (n = 0; n < 8; n++)
            begin
                rs2 = rand_reg();
                imm = 12'($urandom());
                if (n == 0)
                begin
                    rs2      = 5'd0;
                    imm[4:0] = 5'd0;
                end
                if (n == 1)
                begin
                    rs2      = 5'd30;
                    imm[4:0] = 5'd31;
                end
                send_word(op_word(k, rand_reg(), rand_reg(), rs2, imm));
            end
        end
        drain();
        finish_test("all operations");

        // Rotating x5..x8, reading one, two and three instructions back.
        for (n = 0; n < 40; n++)
        begin
            k = ($urandom_range(3) == 0) ? 10 + $urandom_range(8) : $urandom_range(9);
            send_word(op_word(k, 5'(5 + n % 4), 5'(5 + (n + 3) % 4),
                              5'(5 + (n + 1 + $urandom_range(1)) % 4), 12'($urandom())));
        end
        drain();
        finish_test("back-to-back dependencies");

        send_word(i_word(12'h123, 5'd1, 3'd0, 5'd0));
        send_word(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd2));
        send_word(r_word(7'h20, 5'd3, 5'd4, 3'd0, 5'd0));
        send_word(i_word(12'h000, 5'd0, 3'd6, 5'd4));
        send_word(rv_pkg::instr_u'(32'h0000_2283));
        send_word(rv_pkg::instr_u'(32'h0000_006f));
        send_word(rv_pkg::instr_u'(32'hffff_ffff));
        send_word(r_word(7'h01, 5'd3, 5'd4, 3'd0, 5'd5));
        send_word(i_word({7'h20, 5'd3}, 5'd6, 3'd1, 5'd7));
        send_word(i_word({7'h10, 5'd2}, 5'd7, 3'd5, 5'd8));
        send_word(i_word({7'h21, 5'd4}, 5'd9, 3'd5, 5'd11));
        send_word(r_word(7'h00, 5'd0, 5'd5, 3'd0, 5'd9));
        send_word(r_word(7'h00, 5'd8, 5'd7, 3'd0, 5'd10));
        send_word(r_word(7'h00, 5'd0, 5'd11, 3'd6, 5'd12));
        drain();
        finish_test("x0 and illegal instructions");

        sink_max_delay = 24;
        repeat (40) send_word(rand_word());
        drain();
        sink_max_delay = 6;
        finish_test("output credit back-pressure");

        repeat (300) send_word(rand_word());
        drain();
        if (credit_pulses != words_sent)
        begin
            $display("mismatch o_instr_credit pulses: got 0x%0h expected 0x%0h",
                     credit_pulses, words_sent);
            seq_errors++;
        end
        if (src_credits() != rv_pkg::IQ_DEPTH)
        begin
            $display("ERROR: source did not regain all input credits");
            seq_errors++;
        end
        finish_test("input credits");

        $display("tests passed %0d, tests failed %0d, records checked %0d",
                 tests_passed, tests_failed, checks_done);
        if ((tests_failed == 0) && (total_errors() == 0))
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
